//--- files.f
hw/fetch_cfg_pkg.sv
hw/axi_rd_pkg.sv
hw/ifu.sv
hw/icache.sv
hw/fetch_top.sv
verification/axi_rd_mem.sv
verification/tb_fetch.sv

//--- verification/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;
    import fetch_cfg_pkg::*;
    import axi_rd_pkg::*;

    localparam int BLOCK_SIZE = 16;
    localparam int SETS       = 16;
    localparam int WORDS      = BLOCK_SIZE / 4;
    localparam int MAX_CYCLES = 4000;  // About 20 line fills of up to 60 cycles each, with margin
    localparam logic [31:0] INST_MASK    = 32'h5A5A_5A5A;
    localparam logic [3:0]  FAULT_NIBBLE = 4'hF;

    logic        clk;
    logic        rst;
    logic        exu_dnpc_valid;
    logic [31:0] exu_dnpc;
    logic        idu_ready;
    logic        ifu_valid;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_inst;
    logic        access_fault;
    logic        arvalid, arready, rvalid, rready, rlast;
    logic [31:0] araddr, rdata;
    logic [3:0]  arid, rid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst, rresp;

    int value_errors = 0;
    int other_errors = 0;
    int cycles       = 0;
    int words_done   = 0;
    int ar_count     = 0;

    logic [31:0]     exp_pc;
    logic            exp_fault;
    logic            stall_q;
    logic            hold_valid;
    logic [31:0]     hold_pc, hold_inst;
    logic [31:0]     last_araddr;
    logic [SETS-1:0] res_valid;  // Lines the cache should hold, by index
    logic [31:0]     res_line [SETS];

    fetch_top #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .SETS       (SETS)
    ) i_fetch_top (
        .clk (clk), .rst (rst), .exu_dnpc_valid (exu_dnpc_valid), .exu_dnpc (exu_dnpc),
        .idu_ready (idu_ready), .ifu_valid (ifu_valid), .fetch_pc (fetch_pc),
        .fetch_inst (fetch_inst), .access_fault (access_fault),
        .arvalid (arvalid), .araddr (araddr), .arid (arid), .arlen (arlen), .arsize (arsize),
        .arburst (arburst), .rready (rready), .arready (arready), .rvalid (rvalid),
        .rresp (rresp), .rdata (rdata), .rlast (rlast), .rid (rid)
    );

    axi_rd_mem #(
        .SEED (58)
    ) u_axi_rd_mem (
        .clk (clk), .rst (rst), .arvalid (arvalid), .araddr (araddr), .arid (arid),
        .arlen (arlen), .arsize (arsize), .arburst (arburst), .arready (arready),
        .rvalid (rvalid), .rresp (rresp), .rdata (rdata), .rlast (rlast), .rid (rid),
        .rready (rready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        value_errors++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    task automatic finish_run();
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    a_reset_quiet: assert property (
        @(posedge clk) rst |-> !ifu_valid && !arvalid && !rready && !access_fault
    ) else report_problem("fetch or bus outputs active during reset");

    a_redirect_drop: assert property (
        @(posedge clk) disable iff (rst)
        exu_dnpc_valid && idu_ready |=> !ifu_valid
    ) else report_problem("a word fetched in a redirect cycle reached decode");

    // Reference PC, decode hold, fault and cache residency models
    always @(posedge clk) begin : scoreboard
        logic [31:0] line;
        int          idx;
        if (rst) begin
            exp_pc    = RESET_PC;
            exp_fault = 1'b0;
            stall_q   = 1'b0;
            res_valid = '0;
        end else begin
            if (stall_q) begin
                assert (ifu_valid == hold_valid)
                    else report_mismatch("ifu_valid", ifu_valid, hold_valid);
                assert (fetch_pc == hold_pc)
                    else report_mismatch("fetch_pc", fetch_pc, hold_pc);
                assert (fetch_inst == hold_inst)
                    else report_mismatch("fetch_inst", fetch_inst, hold_inst);
            end
            stall_q    = !idu_ready;
            hold_valid = ifu_valid;
            hold_pc    = fetch_pc;
            hold_inst  = fetch_inst;
            if (ifu_valid && idu_ready) begin
                assert (fetch_pc == exp_pc) else report_mismatch("fetch_pc", fetch_pc, exp_pc);
                assert (fetch_inst == (exp_pc ^ INST_MASK))
                    else report_mismatch("fetch_inst", fetch_inst, exp_pc ^ INST_MASK);
                exp_pc = exp_pc + 32'd4;
                words_done++;
            end
            if (exu_dnpc_valid) begin
                exp_pc = exu_dnpc;
            end
            assert (access_fault == exp_fault)
                else report_mismatch("access_fault", access_fault, exp_fault);
            if (rvalid && rready) begin
                exp_fault = (araddr[31:28] == FAULT_NIBBLE);
            end
            if (arvalid && arready) begin
                ar_count++;
                line = araddr & ~(BLOCK_SIZE - 1);
                idx  = int'((line / BLOCK_SIZE) % SETS);
                assert (arsize == SIZE_WORD) else report_mismatch("arsize", arsize, SIZE_WORD);
                assert (arid == FETCH_ID) else report_mismatch("arid", arid, FETCH_ID);
                if (is_sdram(araddr)) begin
                    assert (araddr == line) else report_mismatch("araddr", araddr, line);
                    assert (arlen == 8'(WORDS - 1))
                        else report_mismatch("arlen", arlen, WORDS - 1);
                    assert (arburst == BURST_INCR)
                        else report_mismatch("arburst", arburst, BURST_INCR);
                end else begin
                    assert (arlen == 8'd0) else report_mismatch("arlen", arlen, 0);
                    assert (arburst == BURST_FIXED)
                        else report_mismatch("arburst", arburst, BURST_FIXED);
                    if (araddr != line) begin
                        assert (araddr == last_araddr + 32'd4)
                            else report_mismatch("araddr", araddr, last_araddr + 32'd4);
                    end
                end
                if (araddr == line) begin  // First request of a line fill
                    assert (!(res_valid[idx] && res_line[idx] == line))
                        else report_problem("a line already in the cache was read again");
                    res_valid[idx] = 1'b1;
                    res_line[idx]  = line;
                end
                last_araddr = araddr;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_problem("timeout, the fetch sequence did not complete");
            finish_run();
        end
    end

    task automatic wait_words(input int n);
        int target;
        target = words_done + n;
        while (words_done < target) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic redirect_to(input logic [31:0] target);
        exu_dnpc_valid = 1'b1;
        exu_dnpc       = target;
        @(posedge clk);
        #2;
        exu_dnpc_valid = 1'b0;
    endtask

    task automatic stall_decode(input int n);
        while (!ifu_valid) begin
            @(posedge clk);
            #2;
        end
        idu_ready = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
        idu_ready = 1'b1;
    endtask

    initial begin
        int base_count;
        rst            = 1'b1;
        exu_dnpc_valid = 1'b0;
        exu_dnpc       = '0;
        idu_ready      = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        wait_words(12);  // Three flash lines from the reset vector
        stall_decode(5);
        wait_words(8);

        // These lines are still resident, so no reads are expected
        redirect_to(RESET_PC);
        wait_words(1);
        base_count = ar_count;
        wait_words(7);
        assert (ar_count == base_count) else report_problem("bus reads on a revisited line");

        redirect_to(32'hA000_0000);
        wait_words(12);
        stall_decode(4);
        redirect_to(32'hA000_0100);
        redirect_to(32'hA000_0004);  // Second target lands while the first one still misses
        wait_words(6);

        redirect_to(32'hF000_0000);
        wait_words(4);
        assert (access_fault) else report_mismatch("access_fault", access_fault, 1);
        redirect_to(32'h3000_0200);
        wait_words(4);
        assert (!access_fault) else report_mismatch("access_fault", access_fault, 0);
        finish_run();
    end

endmodule

`default_nettype wire

//--- verification/axi_rd_mem.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_mem #(
    parameter int SEED = 58
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    input  logic [3:0]  arid,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    output logic        arready,
    output logic        rvalid,
    output logic [1:0]  rresp,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic [3:0]  rid,
    input  logic        rready
);
    import axi_rd_pkg::*;

    localparam logic [31:0] DATA_MASK  = 32'h5A5A_5A5A;
    localparam logic [3:0]  ERR_NIBBLE = 4'hF;  // This region answers every beat with SLVERR

    task automatic skip_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One AR handshake followed by arlen+1 data beats
    task automatic serve_read();
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [3:0]  id;
        logic        taken;
        int          beat;
        skip_cycles($urandom_range(3, 0));
        arready = 1'b1;
        addr    = araddr;
        len     = arlen;
        size    = arsize;
        burst   = arburst;
        id      = arid;
        @(posedge clk);
        #2;
        arready = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            skip_cycles($urandom_range(3, 0));
            rvalid = 1'b1;
            rdata  = addr ^ DATA_MASK;
            rresp  = (addr[31:28] == ERR_NIBBLE) ? RESP_SLVERR : RESP_OKAY;
            rlast  = (beat == len);
            rid    = id;
            taken  = 1'b0;
            while (!taken) begin
                taken = rready;  // The level in this cycle decides the handshake at the next edge
                @(posedge clk);
                #2;
            end
            rvalid = 1'b0;
            rlast  = 1'b0;
            if (burst == BURST_INCR) begin
                addr = addr + (32'd1 << size);
            end
        end
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rresp   = RESP_OKAY;
        rdata   = '0;
        rlast   = 1'b0;
        rid     = '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #2;
            if (!rst && arvalid) begin
                serve_read();
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int BLOCK_SIZE = 16,
    parameter int SETS       = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           exu_dnpc_valid,
    input  logic [fetch_cfg_pkg::XLEN-1:0] exu_dnpc,
    input  logic                           idu_ready,
    output logic                           ifu_valid,
    output logic [fetch_cfg_pkg::XLEN-1:0] fetch_pc,
    output logic [fetch_cfg_pkg::XLEN-1:0] fetch_inst,
    output logic                           access_fault,
    output logic                           arvalid,
    output logic [31:0]                    araddr,
    output logic [3:0]                     arid,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic [1:0]                     arburst,
    output logic                           rready,
    input  logic                           arready,
    input  logic                           rvalid,
    input  logic [1:0]                     rresp,
    input  logic [31:0]                    rdata,
    input  logic                           rlast,
    input  logic [3:0]                     rid
);
    import fetch_cfg_pkg::*;

    logic [XLEN-1:0]         icache_addr;
    logic                    icache_hit;
    logic [XLEN-1:0]         icache_data;
    logic                    mem_req;
    logic [XLEN-1:0]         mem_addr;
    logic [BLOCK_SIZE*8-1:0] mem_data;
    logic                    mem_ready;

    ifu #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_ifu (
        .clk            (clk),
        .rst            (rst),
        .exu_dnpc_valid (exu_dnpc_valid),
        .exu_dnpc       (exu_dnpc),
        .idu_ready      (idu_ready),
        .ifu_valid      (ifu_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .access_fault   (access_fault),
        .icache_addr    (icache_addr),
        .icache_hit     (icache_hit),
        .icache_data    (icache_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arid           (arid),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rready         (rready),
        .arready        (arready),
        .rvalid         (rvalid),
        .rresp          (rresp),
        .rdata          (rdata),
        .rlast          (rlast),
        .rid            (rid)
    );

    icache #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .SETS       (SETS)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .icache_addr (icache_addr),
        .mem_ready   (mem_ready),
        .mem_data    (mem_data),
        .icache_hit  (icache_hit),
        .icache_data (icache_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

endmodule

`default_nettype wire

//--- hw/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int BLOCK_SIZE = 16,
    parameter int SETS       = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [fetch_cfg_pkg::XLEN-1:0] icache_addr,
    input  logic                           mem_ready,
    input  logic [BLOCK_SIZE*8-1:0]        mem_data,
    output logic                           icache_hit,
    output logic [fetch_cfg_pkg::XLEN-1:0] icache_data,
    output logic                           mem_req,
    output logic [fetch_cfg_pkg::XLEN-1:0] mem_addr
);
    import fetch_cfg_pkg::*;

    localparam int WORDS  = BLOCK_SIZE / 4;
    localparam int OFF_W  = $clog2(BLOCK_SIZE);
    localparam int IDX_W  = $clog2(SETS);
    localparam int TAG_W  = XLEN - IDX_W - OFF_W;
    localparam int WSEL_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [TAG_W-1:0]        tag_mem  [SETS];
    logic [BLOCK_SIZE*8-1:0] data_mem [SETS];
    logic [SETS-1:0]         valid_q;

    logic [TAG_W-1:0]        look_tag;
    logic [IDX_W-1:0]        look_idx;
    logic [WSEL_W-1:0]       look_word;
    logic [BLOCK_SIZE*8-1:0] look_line;
    logic [TAG_W-1:0]        fill_tag;
    logic [IDX_W-1:0]        fill_idx;

    // Address layout is tag, index, word offset, byte offset
    assign look_tag = icache_addr[XLEN-1 -: TAG_W];
    assign look_idx = icache_addr[OFF_W +: IDX_W];
    assign fill_tag = mem_addr[XLEN-1 -: TAG_W];
    assign fill_idx = mem_addr[OFF_W +: IDX_W];

    generate
        if (WORDS > 1) begin : g_word_sel
            assign look_word = icache_addr[2 +: WSEL_W];
        end else begin : g_one_word
            assign look_word = '0;  // A one-word line has no word offset bits
        end
    endgenerate

    assign look_line   = data_mem[look_idx];
    assign icache_hit  = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);
    assign icache_data = look_line[look_word*32 +: 32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            mem_req <= 1'b0;
        end else begin
            mem_req <= ~icache_hit & ~mem_ready;  // Drops with the fill so the next cycle hits
            if (mem_ready) begin
                valid_q[fill_idx] <= 1'b1;
            end
        end
    end

    // Line base follows the PC, which is held for the whole miss
    always_ff @(posedge clk) begin
        mem_addr <= {icache_addr[XLEN-1:OFF_W], {OFF_W{1'b0}}};
        if (mem_ready) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= mem_data;
        end
    end

    a_fill_only_on_req: assert property (
        @(posedge clk) disable iff (rst)
        mem_ready |-> mem_req
    );

endmodule

`default_nettype wire

//--- hw/ifu.sv
`timescale 1ns/1ps
`default_nettype none

module ifu #(
    parameter int BLOCK_SIZE = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           exu_dnpc_valid,
    input  logic [fetch_cfg_pkg::XLEN-1:0] exu_dnpc,
    input  logic                           idu_ready,
    output logic                           ifu_valid,
    output logic [fetch_cfg_pkg::XLEN-1:0] fetch_pc,
    output logic [fetch_cfg_pkg::XLEN-1:0] fetch_inst,
    output logic                           access_fault,
    output logic [fetch_cfg_pkg::XLEN-1:0] icache_addr,
    input  logic                           icache_hit,
    input  logic [fetch_cfg_pkg::XLEN-1:0] icache_data,
    input  logic                           mem_req,
    input  logic [fetch_cfg_pkg::XLEN-1:0] mem_addr,
    output logic [BLOCK_SIZE*8-1:0]        mem_data,
    output logic                           mem_ready,
    output logic                           arvalid,
    output logic [31:0]                    araddr,
    output logic [3:0]                     arid,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic [1:0]                     arburst,
    output logic                           rready,
    input  logic                           arready,
    input  logic                           rvalid,
    input  logic [1:0]                     rresp,
    input  logic [31:0]                    rdata,
    input  logic                           rlast,
    input  logic [3:0]                     rid
);
    import fetch_cfg_pkg::*;
    import axi_rd_pkg::*;

    localparam int WORDS = BLOCK_SIZE / 4;
    localparam int CNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(WORDS - 1);

    localparam logic IDLE = 1'b0;
    localparam logic BUSY = 1'b1;

    logic             state;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  next_pc;
    logic             pc_update;
    logic             redir_pend;
    logic [XLEN-1:0]  redir_pc;
    logic             redir_take;
    logic [XLEN-1:0]  redir_target;
    logic             start_fill;
    logic             fill_burst;
    logic             ar_fire;
    logic             beat_fire;
    logic             beat_last;
    logic             next_single;
    logic [CNT_W-1:0] beat_cnt;

    assign icache_addr = pc;
    assign arid        = FETCH_ID;
    assign arsize      = SIZE_WORD;

    // A redirect seen while the PC is stalled is kept until the PC can move
    assign redir_take   = exu_dnpc_valid | redir_pend;
    assign redir_target = exu_dnpc_valid ? exu_dnpc : redir_pc;
    assign pc_update    = (state == IDLE) & icache_hit & idu_ready;
    assign next_pc      = redir_take ? redir_target : pc + XLEN'(4);

    assign start_fill  = (state == IDLE) & ~icache_hit & mem_req;
    assign ar_fire     = arvalid & arready;
    assign beat_fire   = rvalid & rready;
    assign beat_last   = fill_burst ? rlast : (beat_cnt == LAST_BEAT);
    assign next_single = beat_fire & ~beat_last & ~fill_burst;  // Issue the next FIXED beat

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= RESET_PC;
            redir_pend <= 1'b0;
        end else if (pc_update) begin
            pc         <= next_pc;
            redir_pend <= 1'b0;
        end else if (exu_dnpc_valid) begin
            redir_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (exu_dnpc_valid) begin
            redir_pc <= exu_dnpc;
        end
    end

    // Decode output register, frozen while decode stalls
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifu_valid <= 1'b0;
        end else if (idu_ready) begin
            ifu_valid <= pc_update & ~redir_take;  // Word on the wrong path is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (pc_update) begin
            fetch_pc   <= pc;
            fetch_inst <= icache_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            mem_ready    <= 1'b0;
            fill_burst   <= 1'b0;
            beat_cnt     <= '0;
            access_fault <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_fill) begin
                        state      <= BUSY;
                        arvalid    <= 1'b1;
                        fill_burst <= is_sdram(mem_addr);
                        beat_cnt   <= '0;
                    end
                end
                BUSY: begin
                    if (mem_ready) begin
                        mem_ready <= 1'b0;  // Line is in the cache now, lookup hits next
                        state     <= IDLE;
                    end
                    if (ar_fire) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat_fire) begin
                        access_fault <= (rresp != RESP_OKAY) || (rid != FETCH_ID);
                        beat_cnt     <= beat_cnt + 1'b1;
                        if (beat_last) begin
                            rready    <= 1'b0;
                            mem_ready <= 1'b1;
                        end else if (!fill_burst) begin
                            rready  <= 1'b0;
                            arvalid <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request fields and the line being assembled
    always_ff @(posedge clk) begin
        if (start_fill) begin
            araddr  <= mem_addr;
            arlen   <= is_sdram(mem_addr) ? 8'(WORDS - 1) : 8'd0;
            arburst <= is_sdram(mem_addr) ? BURST_INCR : BURST_FIXED;
        end else if (next_single) begin
            araddr <= araddr + 32'd4;
        end
        if (beat_fire) begin
            mem_data[beat_cnt*32 +: 32] <= rdata;
        end
    end

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    // Only one transaction is ever in flight
    a_ar_r_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(rready && arvalid)
    );

endmodule

`default_nettype wire

//--- hw/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

    // ARBURST encodings
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    localparam logic [2:0] SIZE_WORD = 3'b010;  // Four bytes per beat

    // RRESP codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [3:0] FETCH_ID = 4'h0;  // All fetch reads share one id

endpackage

`default_nettype wire

//--- hw/fetch_cfg_pkg.sv
`default_nettype none

package fetch_cfg_pkg;

    // Address and instruction width of the core
    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h3000_0000;  // First word fetched after reset

    // Top nibble values that select the SDRAM window A000_0000 to BFFF_FFFF
    localparam logic [3:0] SDRAM_NIBBLE_LO = 4'hA;
    localparam logic [3:0] SDRAM_NIBBLE_HI = 4'hB;

    // SDRAM takes a whole line as one INCR burst, other regions only single beats
    function automatic logic is_sdram(input logic [XLEN-1:0] addr);
        logic [3:0] nibble;
        nibble = addr[XLEN-1 -: 4];
        return (nibble == SDRAM_NIBBLE_LO) || (nibble == SDRAM_NIBBLE_HI);
    endfunction

endpackage

`default_nettype wire
